/* logic/ddr3_pkg.sv */
package ddr3_pkg;

  // DDR3 command set, each code is {RAS_n, CAS_n, WE_n}
  typedef enum logic [2:0] {
    CMD_MRS  = 3'b000,
    CMD_REF  = 3'b001,
    CMD_PRE  = 3'b010,
    CMD_ACT  = 3'b011,
    CMD_WR   = 3'b100,
    CMD_RD   = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOP  = 3'b111
  } ddr3_cmd_e;

  // Widths shared by the whole design
  localparam int BANK_BITS = 3;
  localparam int DATA_BITS = 32;  // One PHY beat
  localparam int MASK_BITS = DATA_BITS / 8;

  // Minimum command gaps, in controller clocks
  localparam int T_RCD = 3;   // ACT to RD or WR
  localparam int T_RP  = 3;   // PRE to ACT or REF
  localparam int T_RFC = 12;  // REF to anything
  localparam int T_MRD = 4;   // MRS and ZQCL
  localparam int T_WR  = 3;   // Write recovery after the data beat

  // Power-up waits, shortened for simulation
  localparam int T_INIT_RESET = 20;  // RESET_n held low
  localparam int T_INIT_CKE   = 24;  // CKE low after reset release

endpackage

/* logic/ddr3_init.sv */
module ddr3_init #(
  parameter int ROW_BITS = 13,
  parameter int DDR_CL = 6,
  parameter int DDR_CWL = 6,
  parameter int REFRESH_CYCLES = 780
) (
  input  logic                           clock,
  input  logic                           reset,
  output logic                           cfg_req_o,
  output ddr3_pkg::ddr3_cmd_e            cfg_cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0] cfg_ba_o,
  output logic [ROW_BITS-1:0]            cfg_adr_o,
  input  logic                           cfg_rdy_i,
  output logic                           cfg_run_o,
  output logic                           ref_req_o,
  output logic                           dfi_rst_no,
  output logic                           dfi_cke_o
);

  typedef enum logic [2:0] {
    ST_RESET, ST_CKE, ST_MR2, ST_MR3, ST_MR1, ST_MR0, ST_ZQCL, ST_RUN
  } init_state_e;

  localparam int REF_BITS = $clog2(REFRESH_CYCLES + 1);

  init_state_e         state;
  logic [15:0]         wait_cnt;
  logic [REF_BITS-1:0] ref_cnt;

  // Mode register contents for each load step
  always_comb begin
    cfg_req_o = 1'b1;
    cfg_cmd_o = ddr3_pkg::CMD_MRS;
    cfg_ba_o  = '0;
    cfg_adr_o = '0;
    case (state)
      ST_MR2: begin
        cfg_ba_o  = ddr3_pkg::BANK_BITS'(2);
        cfg_adr_o = ROW_BITS'((DDR_CWL - 5) << 3);  // CWL in A5:A3
      end
      ST_MR3: cfg_ba_o = ddr3_pkg::BANK_BITS'(3);
      ST_MR1: begin
        cfg_ba_o  = ddr3_pkg::BANK_BITS'(1);
        cfg_adr_o = ROW_BITS'(1);  // DLL disable
      end
      ST_MR0: cfg_adr_o = ROW_BITS'((DDR_CL - 4) << 4);  // CL in A6:A4
      ST_ZQCL: begin
        cfg_cmd_o     = ddr3_pkg::CMD_ZQCL;
        cfg_adr_o[10] = 1'b1;  // Long calibration
      end
      default: begin
        cfg_req_o = 1'b0;
        cfg_cmd_o = ddr3_pkg::CMD_NOP;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ST_RESET;
      wait_cnt   <= 16'(ddr3_pkg::T_INIT_RESET - 1);
      dfi_rst_no <= 1'b0;
      dfi_cke_o  <= 1'b0;
      cfg_run_o  <= 1'b0;
    end else begin
      case (state)
        ST_RESET: begin
          if (wait_cnt == 0) begin
            dfi_rst_no <= 1'b1;
            wait_cnt   <= 16'(ddr3_pkg::T_INIT_CKE - 1);
            state      <= ST_CKE;
          end else begin
            wait_cnt <= wait_cnt - 16'd1;
          end
        end
        ST_CKE: begin
          if (wait_cnt == 0) begin
            dfi_cke_o <= 1'b1;
            state     <= ST_MR2;
          end else begin
            wait_cnt <= wait_cnt - 16'd1;
          end
        end
        ST_MR2: if (cfg_rdy_i) state <= ST_MR3;
        ST_MR3: if (cfg_rdy_i) state <= ST_MR1;
        ST_MR1: if (cfg_rdy_i) state <= ST_MR0;
        ST_MR0: if (cfg_rdy_i) state <= ST_ZQCL;
        ST_ZQCL: begin
          if (cfg_rdy_i) begin
            cfg_run_o <= 1'b1;  // Controller owns the bus from here
            state     <= ST_RUN;
          end
        end
        default: state <= ST_RUN;
      endcase
    end
  end

  // Periodic refresh strobe once running
  always_ff @(posedge clock) begin
    if (reset) begin
      ref_cnt   <= '0;
      ref_req_o <= 1'b0;
    end else if (state == ST_ZQCL && cfg_rdy_i) begin
      ref_cnt <= REF_BITS'(REFRESH_CYCLES - 1);
    end else if (state == ST_RUN) begin
      if (ref_cnt == 0) begin
        ref_req_o <= 1'b1;
        ref_cnt   <= REF_BITS'(REFRESH_CYCLES - 1);
      end else begin
        ref_req_o <= 1'b0;
        ref_cnt   <= ref_cnt - 1'b1;
      end
    end
  end

endmodule

/* logic/ddr3_fsm.sv */
module ddr3_fsm #(
  parameter int ROW_BITS = 13,
  parameter int COL_BITS = 10
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        cfg_run_i,
  input  logic                                        cfg_req_i,
  output logic                                        cfg_rdy_o,
  input  ddr3_pkg::ddr3_cmd_e                         cfg_cmd_i,
  input  logic [ddr3_pkg::BANK_BITS-1:0]              cfg_ba_i,
  input  logic [ROW_BITS-1:0]                         cfg_adr_i,
  input  logic                                        ref_req_i,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  logic                                        req_write_i,
  input  logic [ddr3_pkg::BANK_BITS+ROW_BITS+COL_BITS-1:0] req_addr_i,
  input  logic [ddr3_pkg::DATA_BITS-1:0]              req_wdata_i,
  input  logic [ddr3_pkg::MASK_BITS-1:0]              req_wmask_i,
  output logic                                        wr_done_o,
  output logic                                        cmd_valid_o,
  input  logic                                        cmd_ready_i,
  output ddr3_pkg::ddr3_cmd_e                         cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]              cmd_ba_o,
  output logic [ROW_BITS-1:0]                         cmd_adr_o,
  output logic [ddr3_pkg::DATA_BITS-1:0]              cmd_wdata_o,
  output logic [ddr3_pkg::MASK_BITS-1:0]              cmd_wmask_o
);

  localparam int NUM_BANKS = 1 << ddr3_pkg::BANK_BITS;

  typedef enum logic [2:0] {S_IDLE, S_PREA, S_REF, S_PRE, S_ACT, S_ACCESS} fsm_state_e;

  fsm_state_e                      state;
  logic                            ref_pend;
  logic [NUM_BANKS-1:0]            bank_open;
  logic [ROW_BITS-1:0]             open_row [NUM_BANKS];
  logic                            write_q;
  logic [ddr3_pkg::BANK_BITS-1:0]  ba_q;
  logic [ROW_BITS-1:0]             row_q;
  logic [COL_BITS-1:0]             col_q;
  logic [ddr3_pkg::BANK_BITS-1:0]  req_ba;
  logic [ROW_BITS-1:0]             req_row;
  logic                            accept;
  logic                            fire;

  // Address split, bank on top
  assign req_ba  = req_addr_i[ddr3_pkg::BANK_BITS+ROW_BITS+COL_BITS-1 -: ddr3_pkg::BANK_BITS];
  assign req_row = req_addr_i[COL_BITS +: ROW_BITS];

  assign req_ready_o = (state == S_IDLE) && cfg_run_i && !ref_pend && cmd_ready_i;
  assign accept      = req_valid_i && req_ready_o;
  assign fire        = cmd_valid_o && cmd_ready_i;
  assign wr_done_o   = fire && (state == S_ACCESS) && write_q;

  // Command select per state
  always_comb begin
    cmd_valid_o = 1'b0;
    cmd_o       = ddr3_pkg::CMD_NOP;
    cmd_ba_o    = ba_q;
    cmd_adr_o   = '0;
    cfg_rdy_o   = 1'b0;
    case (state)
      S_IDLE: begin
        if (!cfg_run_i) begin  // Sequencer owns the bus
          cmd_valid_o = cfg_req_i;
          cmd_o       = cfg_cmd_i;
          cmd_ba_o    = cfg_ba_i;
          cmd_adr_o   = cfg_adr_i;
          cfg_rdy_o   = cmd_ready_i;
        end
      end
      S_PREA: begin
        cmd_valid_o   = 1'b1;
        cmd_o         = ddr3_pkg::CMD_PRE;
        cmd_adr_o[10] = 1'b1;  // All banks
      end
      S_REF: begin
        cmd_valid_o = 1'b1;
        cmd_o       = ddr3_pkg::CMD_REF;
      end
      S_PRE: begin
        cmd_valid_o = 1'b1;
        cmd_o       = ddr3_pkg::CMD_PRE;
      end
      S_ACT: begin
        cmd_valid_o = 1'b1;
        cmd_o       = ddr3_pkg::CMD_ACT;
        cmd_adr_o   = row_q;
      end
      S_ACCESS: begin
        cmd_valid_o = 1'b1;
        cmd_o       = write_q ? ddr3_pkg::CMD_WR : ddr3_pkg::CMD_RD;
        cmd_adr_o   = {{(ROW_BITS - COL_BITS){1'b0}}, col_q};  // A10 low, no auto-precharge
      end
      default: cmd_valid_o = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= S_IDLE;
      ref_pend  <= 1'b0;
      bank_open <= '0;
    end else begin
      if (ref_req_i) begin
        ref_pend <= 1'b1;
      end else if (state == S_REF && fire) begin
        ref_pend <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (cfg_run_i && ref_pend && cmd_ready_i) begin
            state <= S_PREA;
          end else if (accept) begin
            if (!bank_open[req_ba]) state <= S_ACT;
            else if (open_row[req_ba] == req_row) state <= S_ACCESS;  // Row hit
            else state <= S_PRE;
          end
        end
        S_PREA: begin
          if (fire) begin
            bank_open <= '0;
            state     <= S_REF;
          end
        end
        S_REF: if (fire) state <= S_IDLE;
        S_PRE: begin
          if (fire) begin
            bank_open[ba_q] <= 1'b0;
            state           <= S_ACT;
          end
        end
        S_ACT: begin
          if (fire) begin
            bank_open[ba_q] <= 1'b1;
            state           <= S_ACCESS;
          end
        end
        S_ACCESS: if (fire) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Request payload and open rows
  always_ff @(posedge clock) begin
    if (accept) begin
      write_q     <= req_write_i;
      ba_q        <= req_ba;
      row_q       <= req_row;
      col_q       <= req_addr_i[COL_BITS-1:0];
      cmd_wdata_o <= req_wdata_i;
      cmd_wmask_o <= req_wmask_i;
    end
    if (state == S_ACT && fire) open_row[ba_q] <= row_q;
  end

endmodule

/* logic/ddr3_ddl.sv */
module ddr3_ddl #(
  parameter int ROW_BITS = 13,
  parameter int DDR_CL = 6,
  parameter int DDR_CWL = 6
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           cmd_valid_i,
  output logic                           cmd_ready_o,
  input  ddr3_pkg::ddr3_cmd_e            cmd_i,
  input  logic [ddr3_pkg::BANK_BITS-1:0] cmd_ba_i,
  input  logic [ROW_BITS-1:0]            cmd_adr_i,
  input  logic [ddr3_pkg::DATA_BITS-1:0] cmd_wdata_i,
  input  logic [ddr3_pkg::MASK_BITS-1:0] cmd_wmask_i,
  output logic                           rd_valid_o,
  output logic [ddr3_pkg::DATA_BITS-1:0] rd_data_o,
  output logic                           dfi_cs_no,
  output logic                           dfi_ras_no,
  output logic                           dfi_cas_no,
  output logic                           dfi_we_no,
  output logic [ddr3_pkg::BANK_BITS-1:0] dfi_bank_o,
  output logic [ROW_BITS-1:0]            dfi_addr_o,
  output logic                           dfi_wren_o,
  output logic [ddr3_pkg::MASK_BITS-1:0] dfi_mask_o,
  output logic [ddr3_pkg::DATA_BITS-1:0] dfi_data_o,
  output logic                           dfi_rden_o,
  input  logic                           dfi_rvld_i,
  input  logic [ddr3_pkg::DATA_BITS-1:0] dfi_data_i
);

  logic               fire;
  logic [7:0]         gap_cnt;
  logic               rd_wait;  // RD issued, data not back yet
  logic [DDR_CWL:0]   wr_sr;
  logic [DDR_CL:0]    rd_sr;

  // Cycles before the next command may be accepted, minus one
  function automatic logic [7:0] gap_of(ddr3_pkg::ddr3_cmd_e c);
    case (c)
      ddr3_pkg::CMD_ACT:  return 8'(ddr3_pkg::T_RCD - 1);
      ddr3_pkg::CMD_PRE:  return 8'(ddr3_pkg::T_RP - 1);
      ddr3_pkg::CMD_REF:  return 8'(ddr3_pkg::T_RFC - 1);
      ddr3_pkg::CMD_MRS,
      ddr3_pkg::CMD_ZQCL: return 8'(ddr3_pkg::T_MRD - 1);
      ddr3_pkg::CMD_WR:   return 8'(DDR_CWL + ddr3_pkg::T_WR - 1);
      default:            return 8'd0;
    endcase
  endfunction

  assign cmd_ready_o = (gap_cnt == 0) && !rd_wait;
  assign fire        = cmd_valid_i && cmd_ready_o;

  assign dfi_wren_o = wr_sr[DDR_CWL];
  assign dfi_rden_o = rd_sr[DDR_CL];
  assign rd_valid_o = dfi_rvld_i && rd_wait;
  assign rd_data_o  = dfi_data_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      dfi_cs_no  <= 1'b1;
      {dfi_ras_no, dfi_cas_no, dfi_we_no} <= ddr3_pkg::CMD_NOP;
      gap_cnt    <= '0;
      rd_wait    <= 1'b0;
      wr_sr      <= '0;
      rd_sr      <= '0;
    end else begin
      dfi_cs_no <= !fire;  // One-cycle command slot
      {dfi_ras_no, dfi_cas_no, dfi_we_no} <= fire ? cmd_i : ddr3_pkg::CMD_NOP;
      if (fire) gap_cnt <= gap_of(cmd_i);
      else if (gap_cnt != 0) gap_cnt <= gap_cnt - 8'd1;
      if (fire && cmd_i == ddr3_pkg::CMD_RD) rd_wait <= 1'b1;
      else if (dfi_rvld_i) rd_wait <= 1'b0;
      // Latency lines for the data enables
      wr_sr <= {wr_sr[DDR_CWL-1:0], fire && cmd_i == ddr3_pkg::CMD_WR};
      rd_sr <= {rd_sr[DDR_CL-1:0], fire && cmd_i == ddr3_pkg::CMD_RD};
    end
  end

  // Address and write beat, held until the next command
  always_ff @(posedge clock) begin
    if (fire) begin
      dfi_bank_o <= cmd_ba_i;
      dfi_addr_o <= cmd_adr_i;
    end
    if (fire && cmd_i == ddr3_pkg::CMD_WR) begin
      dfi_data_o <= cmd_wdata_i;
      dfi_mask_o <= cmd_wmask_i;
    end
  end

endmodule

/* logic/ddr3_lite_top.sv */
module ddr3_lite_top #(
  parameter int ROW_BITS = 13,
  parameter int COL_BITS = 10,
  parameter int DDR_CL = 6,
  parameter int DDR_CWL = 6,
  parameter int REFRESH_CYCLES = 780
) (
  input  logic                                             clock,
  input  logic                                             reset,
  input  logic                                             req_valid_i,
  output logic                                             req_ready_o,
  input  logic                                             req_write_i,
  input  logic [ddr3_pkg::BANK_BITS+ROW_BITS+COL_BITS-1:0] req_addr_i,
  input  logic [ddr3_pkg::DATA_BITS-1:0]                   req_wdata_i,
  input  logic [ddr3_pkg::MASK_BITS-1:0]                   req_wmask_i,
  output logic                                             rd_valid_o,
  output logic [ddr3_pkg::DATA_BITS-1:0]                   rd_data_o,
  output logic                                             wr_done_o,
  output logic                                             init_done_o,
  output logic                                             dfi_rst_no,
  output logic                                             dfi_cke_o,
  output logic                                             dfi_cs_no,
  output logic                                             dfi_ras_no,
  output logic                                             dfi_cas_no,
  output logic                                             dfi_we_no,
  output logic                                             dfi_odt_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]                   dfi_bank_o,
  output logic [ROW_BITS-1:0]                              dfi_addr_o,
  output logic                                             dfi_wren_o,
  output logic [ddr3_pkg::MASK_BITS-1:0]                   dfi_mask_o,
  output logic [ddr3_pkg::DATA_BITS-1:0]                   dfi_data_o,
  output logic                                             dfi_rden_o,
  input  logic                                             dfi_rvld_i,
  input  logic [ddr3_pkg::DATA_BITS-1:0]                   dfi_data_i
);

  // Sequencer to controller
  logic                           cfg_req, cfg_rdy, cfg_run, ref_req;
  ddr3_pkg::ddr3_cmd_e            cfg_cmd;
  logic [ddr3_pkg::BANK_BITS-1:0] cfg_ba;
  logic [ROW_BITS-1:0]            cfg_adr;

  // Controller to command layer
  logic                           cmd_valid, cmd_ready;
  ddr3_pkg::ddr3_cmd_e            cmd;
  logic [ddr3_pkg::BANK_BITS-1:0] cmd_ba;
  logic [ROW_BITS-1:0]            cmd_adr;
  logic [ddr3_pkg::DATA_BITS-1:0] cmd_wdata;
  logic [ddr3_pkg::MASK_BITS-1:0] cmd_wmask;

  assign dfi_odt_o   = 1'b0;  // No ODT scheduling
  assign init_done_o = cfg_run;

  ddr3_init #(
    .ROW_BITS(ROW_BITS), .DDR_CL(DDR_CL), .DDR_CWL(DDR_CWL), .REFRESH_CYCLES(REFRESH_CYCLES)
  ) ddr3_init_i (
    .clock(clock), .reset(reset),
    .cfg_req_o(cfg_req), .cfg_cmd_o(cfg_cmd), .cfg_ba_o(cfg_ba), .cfg_adr_o(cfg_adr),
    .cfg_rdy_i(cfg_rdy), .cfg_run_o(cfg_run), .ref_req_o(ref_req),
    .dfi_rst_no(dfi_rst_no), .dfi_cke_o(dfi_cke_o)
  );

  ddr3_fsm #(.ROW_BITS(ROW_BITS), .COL_BITS(COL_BITS)) ddr3_fsm_i (
    .clock(clock), .reset(reset),
    .cfg_run_i(cfg_run), .cfg_req_i(cfg_req), .cfg_rdy_o(cfg_rdy),
    .cfg_cmd_i(cfg_cmd), .cfg_ba_i(cfg_ba), .cfg_adr_i(cfg_adr), .ref_req_i(ref_req),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_write_i(req_write_i),
    .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i), .req_wmask_i(req_wmask_i),
    .wr_done_o(wr_done_o), .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready),
    .cmd_o(cmd), .cmd_ba_o(cmd_ba), .cmd_adr_o(cmd_adr),
    .cmd_wdata_o(cmd_wdata), .cmd_wmask_o(cmd_wmask)
  );

  ddr3_ddl #(.ROW_BITS(ROW_BITS), .DDR_CL(DDR_CL), .DDR_CWL(DDR_CWL)) ddr3_ddl_i (
    .clock(clock), .reset(reset),
    .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_i(cmd),
    .cmd_ba_i(cmd_ba), .cmd_adr_i(cmd_adr), .cmd_wdata_i(cmd_wdata), .cmd_wmask_i(cmd_wmask),
    .rd_valid_o(rd_valid_o), .rd_data_o(rd_data_o),
    .dfi_cs_no(dfi_cs_no), .dfi_ras_no(dfi_ras_no), .dfi_cas_no(dfi_cas_no),
    .dfi_we_no(dfi_we_no), .dfi_bank_o(dfi_bank_o), .dfi_addr_o(dfi_addr_o),
    .dfi_wren_o(dfi_wren_o), .dfi_mask_o(dfi_mask_o), .dfi_data_o(dfi_data_o),
    .dfi_rden_o(dfi_rden_o), .dfi_rvld_i(dfi_rvld_i), .dfi_data_i(dfi_data_i)
  );

endmodule

/* tests/dfi_mem_model.sv */
module dfi_mem_model #(
  parameter int ROW_BITS = 13,
  parameter int COL_BITS = 10
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dfi_cke_i,
  input  logic                           dfi_cs_ni,
  input  logic                           dfi_ras_ni,
  input  logic                           dfi_cas_ni,
  input  logic                           dfi_we_ni,
  input  logic [ddr3_pkg::BANK_BITS-1:0] dfi_bank_i,
  input  logic [ROW_BITS-1:0]            dfi_addr_i,
  input  logic                           dfi_wren_i,
  input  logic [ddr3_pkg::MASK_BITS-1:0] dfi_mask_i,
  input  logic [ddr3_pkg::DATA_BITS-1:0] dfi_data_i,
  input  logic                           dfi_rden_i,
  output logic                           dfi_rvld_o,
  output logic [ddr3_pkg::DATA_BITS-1:0] dfi_data_o,
  output int                             mrs_count_o,
  output int                             zq_count_o,
  output int                             ref_count_o
);

  localparam int ADDR_BITS = ddr3_pkg::BANK_BITS + ROW_BITS + COL_BITS;

  logic [ddr3_pkg::DATA_BITS-1:0] mem [logic [ADDR_BITS-1:0]];  // Sparse, bank on top
  logic [ROW_BITS-1:0]            open_row [1 << ddr3_pkg::BANK_BITS];
  logic [ADDR_BITS-1:0]           wr_addr_q [$];
  logic [ADDR_BITS-1:0]           rd_addr_q [$];
  logic [ADDR_BITS-1:0]           wr_addr;
  logic [ADDR_BITS-1:0]           rd_addr;
  logic [ADDR_BITS-1:0]           cmd_addr;
  logic [2:0]                     pin_cmd;
  logic                           rvld_q = 1'b0;
  logic [ddr3_pkg::DATA_BITS-1:0] rdata_q = '0;

  assign pin_cmd    = {dfi_ras_ni, dfi_cas_ni, dfi_we_ni};
  assign cmd_addr   = {dfi_bank_i, open_row[dfi_bank_i], dfi_addr_i[COL_BITS-1:0]};
  assign dfi_rvld_o = rvld_q;
  assign dfi_data_o = rdata_q;

  // A set mask bit keeps the stored byte
  function automatic logic [ddr3_pkg::DATA_BITS-1:0] merge_bytes(
    input logic [ddr3_pkg::DATA_BITS-1:0] old_word,
    input logic [ddr3_pkg::DATA_BITS-1:0] new_word,
    input logic [ddr3_pkg::MASK_BITS-1:0] mask
  );
    logic [ddr3_pkg::DATA_BITS-1:0] result;
    result = old_word;
    for (int i = 0; i < ddr3_pkg::MASK_BITS; i++) begin
      if (!mask[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      rvld_q      <= 1'b0;
      mrs_count_o <= 0;
      zq_count_o  <= 0;
      ref_count_o <= 0;
    end else begin
      rvld_q <= dfi_rden_i;  // Data one cycle after the read enable
      if (!dfi_cs_ni && dfi_cke_i) begin
        case (pin_cmd)
          ddr3_pkg::CMD_MRS:  mrs_count_o <= mrs_count_o + 1;
          ddr3_pkg::CMD_ZQCL: zq_count_o <= zq_count_o + 1;
          ddr3_pkg::CMD_REF:  ref_count_o <= ref_count_o + 1;
          ddr3_pkg::CMD_ACT:  open_row[dfi_bank_i] <= dfi_addr_i;
          ddr3_pkg::CMD_WR:   wr_addr_q.push_back(cmd_addr);
          ddr3_pkg::CMD_RD:   rd_addr_q.push_back(cmd_addr);
          default: ;
        endcase
      end
      if (dfi_wren_i && wr_addr_q.size() > 0) begin
        wr_addr      = wr_addr_q.pop_front();
        mem[wr_addr] = merge_bytes(mem.exists(wr_addr) ? mem[wr_addr] : '0,
                                   dfi_data_i, dfi_mask_i);
      end
      if (dfi_rden_i && rd_addr_q.size() > 0) begin
        rd_addr = rd_addr_q.pop_front();
        rdata_q <= mem.exists(rd_addr) ? mem[rd_addr] : '0;  // Unwritten words read zero
      end
    end
  end

endmodule

/* tests/ddr3_lite_checker.sv */
module ddr3_lite_checker #(
  parameter int DDR_CL  = 6,
  parameter int DDR_CWL = 6
) (
  input logic clock,
  input logic reset,
  input logic req_ready_i,
  input logic init_done_i,
  input logic rd_valid_i,
  input logic wr_done_i,
  input logic dfi_cs_ni,
  input logic dfi_ras_ni,
  input logic dfi_cas_ni,
  input logic dfi_we_ni,
  input logic dfi_wren_i,
  input logic dfi_rden_i
);

  int   assert_fails = 0;
  logic wr_cmd;
  logic rd_cmd;

  // Commands as they appear on the pins
  assign wr_cmd = !dfi_cs_ni && ({dfi_ras_ni, dfi_cas_ni, dfi_we_ni} == ddr3_pkg::CMD_WR);
  assign rd_cmd = !dfi_cs_ni && ({dfi_ras_ni, dfi_cas_ni, dfi_we_ni} == ddr3_pkg::CMD_RD);

  ready_needs_init: assert property (@(posedge clock) disable iff (reset)
    req_ready_i |-> init_done_i)
    else begin
      assert_fails++;
      $error("Request port ready while init is not done");
    end

  rd_valid_single: assert property (@(posedge clock) disable iff (reset)
    rd_valid_i |=> !rd_valid_i)
    else begin
      assert_fails++;
      $error("Read valid strobe held for two cycles");
    end

  wr_done_single: assert property (@(posedge clock) disable iff (reset)
    wr_done_i |=> !wr_done_i)
    else begin
      assert_fails++;
      $error("Write done strobe held for two cycles");
    end

  // Write beat exactly CWL after WR
  wren_after_wr: assert property (@(posedge clock) disable iff (reset)
    wr_cmd |-> ##DDR_CWL (dfi_wren_i && !dfi_rden_i))
    else begin
      assert_fails++;
      $error("Write enable missing CWL cycles after WR");
    end

  rden_after_rd: assert property (@(posedge clock) disable iff (reset)
    rd_cmd |-> ##DDR_CL (dfi_rden_i && !dfi_wren_i))
    else begin
      assert_fails++;
      $error("Read enable missing CL cycles after RD");
    end

endmodule

bind ddr3_lite_top ddr3_lite_checker #(.DDR_CL(DDR_CL), .DDR_CWL(DDR_CWL)) ddr3_lite_checker_i (
  .clock(clock), .reset(reset),
  .req_ready_i(req_ready_o), .init_done_i(init_done_o),
  .rd_valid_i(rd_valid_o), .wr_done_i(wr_done_o),
  .dfi_cs_ni(dfi_cs_no), .dfi_ras_ni(dfi_ras_no), .dfi_cas_ni(dfi_cas_no), .dfi_we_ni(dfi_we_no),
  .dfi_wren_i(dfi_wren_o), .dfi_rden_i(dfi_rden_o)
);

/* tests/ddr3_lite_tb.sv */
module ddr3_lite_tb;

  localparam int ROW_BITS       = 13;
  localparam int COL_BITS       = 10;
  localparam int DDR_CL         = 6;
  localparam int DDR_CWL        = 6;
  localparam int REFRESH_CYCLES = 200;  // Short so refresh lands between accesses
  localparam int ADDR_BITS      = ddr3_pkg::BANK_BITS + ROW_BITS + COL_BITS;
  localparam int DATA_BITS      = ddr3_pkg::DATA_BITS;
  localparam int MASK_BITS      = ddr3_pkg::MASK_BITS;
  localparam int SEED           = 32'h333d;
  localparam int IDLE_CYCLES    = 2000;
  localparam int INIT_CYCLES    = ddr3_pkg::T_INIT_RESET + ddr3_pkg::T_INIT_CKE
                                  + 5 * ddr3_pkg::T_MRD + 10;
  // Write recovery, refresh, PRE, ACT and read latency back to back
  localparam int ACCESS_CYCLES  = DDR_CWL + ddr3_pkg::T_WR + 2 * ddr3_pkg::T_RP
                                  + ddr3_pkg::T_RFC + ddr3_pkg::T_RCD + DDR_CL + 10;

  typedef struct {
    string                name;
    bit                   write;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
    logic [MASK_BITS-1:0] mask;
  } step_t;

  logic                           clock;
  logic                           reset;
  logic                           req_valid, req_ready, req_write;
  logic [ADDR_BITS-1:0]           req_addr;
  logic [DATA_BITS-1:0]           req_wdata;
  logic [MASK_BITS-1:0]           req_wmask;
  logic                           rd_valid, wr_done, init_done;
  logic [DATA_BITS-1:0]           rd_data;
  logic                           dfi_rst_n, dfi_cke, dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n;
  logic                           dfi_odt, dfi_wren, dfi_rden, dfi_rvld;
  logic [ddr3_pkg::BANK_BITS-1:0] dfi_bank;
  logic [ROW_BITS-1:0]            dfi_addr;
  logic [MASK_BITS-1:0]           dfi_mask;
  logic [DATA_BITS-1:0]           dfi_wdata, dfi_rdata;
  int                             mrs_count, zq_count, ref_count;

  step_t                steps [$];
  logic [DATA_BITS-1:0] ref_mem [logic [ADDR_BITS-1:0]];  // Expected memory contents
  int                   errors = 0;
  int                   cycle_count = 0;
  int                   cycle_limit;

  ddr3_lite_top #(
    .ROW_BITS(ROW_BITS), .COL_BITS(COL_BITS), .DDR_CL(DDR_CL), .DDR_CWL(DDR_CWL),
    .REFRESH_CYCLES(REFRESH_CYCLES)
  ) ddr3_lite_top_i (
    .clock(clock), .reset(reset),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_write_i(req_write),
    .req_addr_i(req_addr), .req_wdata_i(req_wdata), .req_wmask_i(req_wmask),
    .rd_valid_o(rd_valid), .rd_data_o(rd_data), .wr_done_o(wr_done), .init_done_o(init_done),
    .dfi_rst_no(dfi_rst_n), .dfi_cke_o(dfi_cke), .dfi_cs_no(dfi_cs_n), .dfi_ras_no(dfi_ras_n),
    .dfi_cas_no(dfi_cas_n), .dfi_we_no(dfi_we_n), .dfi_odt_o(dfi_odt),
    .dfi_bank_o(dfi_bank), .dfi_addr_o(dfi_addr), .dfi_wren_o(dfi_wren),
    .dfi_mask_o(dfi_mask), .dfi_data_o(dfi_wdata), .dfi_rden_o(dfi_rden),
    .dfi_rvld_i(dfi_rvld), .dfi_data_i(dfi_rdata)
  );

  dfi_mem_model #(.ROW_BITS(ROW_BITS), .COL_BITS(COL_BITS)) mem_model_i (
    .clock(clock), .reset(reset), .dfi_cke_i(dfi_cke), .dfi_cs_ni(dfi_cs_n),
    .dfi_ras_ni(dfi_ras_n), .dfi_cas_ni(dfi_cas_n), .dfi_we_ni(dfi_we_n),
    .dfi_bank_i(dfi_bank), .dfi_addr_i(dfi_addr), .dfi_wren_i(dfi_wren),
    .dfi_mask_i(dfi_mask), .dfi_data_i(dfi_wdata), .dfi_rden_i(dfi_rden),
    .dfi_rvld_o(dfi_rvld), .dfi_data_o(dfi_rdata),
    .mrs_count_o(mrs_count), .zq_count_o(zq_count), .ref_count_o(ref_count)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: no response after %0d cycles", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [ADDR_BITS-1:0] make_addr(input int bank, input int row, input int col);
    return {ddr3_pkg::BANK_BITS'(bank), ROW_BITS'(row), COL_BITS'(col)};
  endfunction

  // Set mask bit leaves that byte as it was
  function automatic logic [DATA_BITS-1:0] apply_mask(input logic [DATA_BITS-1:0] old_word,
                                                      input logic [DATA_BITS-1:0] new_word,
                                                      input logic [MASK_BITS-1:0] mask);
    logic [DATA_BITS-1:0] result;
    result = old_word;
    for (int i = 0; i < MASK_BITS; i++) begin
      if (!mask[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  function automatic logic [DATA_BITS-1:0] expected_read(input logic [ADDR_BITS-1:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : '0;
  endfunction

  function automatic void add_step(input string name, input bit write, input int bank,
                                   input int row, input int col, input logic [MASK_BITS-1:0] mask);
    step_t s;
    s.name  = name;
    s.write = write;
    s.addr  = make_addr(bank, row, col);
    s.data  = write ? DATA_BITS'($urandom) : '0;
    s.mask  = mask;
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    add_step("wr_base", 1, 0, 5, 8, 4'h0);
    add_step("rd_base", 0, 0, 5, 8, 4'h0);
    add_step("wr_partial", 1, 0, 5, 8, 4'b1010);
    add_step("rd_partial", 0, 0, 5, 8, 4'h0);
    add_step("wr_row_b", 1, 0, 9, 8, 4'h0);  // Other row in the same bank
    add_step("rd_row_a", 0, 0, 5, 8, 4'h0);
    add_step("rd_row_b", 0, 0, 9, 8, 4'h0);
    add_step("wr_row_a_col", 1, 0, 5, 300, 4'h0);
    add_step("rd_row_b_again", 0, 0, 9, 8, 4'h0);
    add_step("rd_row_a_col", 0, 0, 5, 300, 4'h0);
    add_step("wr_bank1", 1, 1, 17, 4, 4'h0);
    add_step("wr_bank2", 1, 2, 100, 1023, 4'h0);
    add_step("wr_bank3", 1, 3, 8191, 0, 4'h0);
    add_step("wr_bank7", 1, 7, 42, 77, 4'b0110);
    add_step("rd_bank1", 0, 1, 17, 4, 4'h0);  // Rows stay open from here
    add_step("rd_bank2", 0, 2, 100, 1023, 4'h0);
    add_step("rd_bank3", 0, 3, 8191, 0, 4'h0);
    add_step("rd_bank7", 0, 7, 42, 77, 4'h0);
    add_step("wr_bank2_hit", 1, 2, 100, 12, 4'h0);
    add_step("rd_bank2_hit", 0, 2, 100, 12, 4'h0);
    add_step("rd_unwritten", 0, 5, 3, 3, 4'h0);
  endfunction

  task automatic check_init();
    assert (!dfi_rst_n && !dfi_cke && dfi_cs_n) else begin
      errors++;
      $display("DFI reset, CKE or chip select not idle after reset");
    end
    while (!init_done) begin
      assert (!req_ready) else begin
        errors++;
        $display("Request port became ready before init finished");
      end
      @(negedge clock);
    end
    assert (mrs_count == 4) else begin
      errors++;
      $display("Mismatch init_mrs: expected %0d, actual %0d", 4, mrs_count);
    end
    assert (dfi_cke && dfi_rst_n && !dfi_odt) else begin
      errors++;
      $display("CKE or RESET_n low, or ODT high, when init finished");
    end
    @(negedge clock);  // ZQCL reaches the model one cycle later
    assert (zq_count == 1) else begin
      errors++;
      $display("Mismatch init_zqcl: expected %0d, actual %0d", 1, zq_count);
    end
  endtask

  task automatic run_step(input string name, input bit write, input logic [ADDR_BITS-1:0] addr,
                          input logic [DATA_BITS-1:0] data, input logic [MASK_BITS-1:0] mask);
    logic [DATA_BITS-1:0] expected;
    @(negedge clock);
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = data;
    req_wmask = mask;
    while (!req_ready) @(negedge clock);
    @(negedge clock);  // Accepted on the rising edge just passed
    req_valid = 1'b0;
    while (!(wr_done || rd_valid)) @(negedge clock);
    assert (!dfi_odt) else begin
      errors++;
      $display("%s: ODT driven high", name);
    end
    if (write) begin
      assert (wr_done && !rd_valid) else begin
        errors++;
        $display("%s: write ended without a lone write done strobe", name);
      end
      ref_mem[addr] = apply_mask(expected_read(addr), data, mask);
    end else begin
      expected = expected_read(addr);
      assert (rd_valid && !wr_done) else begin
        errors++;
        $display("%s: read ended without a lone read valid strobe", name);
      end
      assert (rd_data == expected) else begin
        errors++;
        $display("Mismatch %s: expected %h, actual %h", name, expected, rd_data);
      end
    end
  endtask

  initial begin
    int ref_start;
    int refs;
    clock     = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_wmask = '0;
    void'($urandom(SEED));
    build_table();
    cycle_limit = INIT_CYCLES + 2 * steps.size() * ACCESS_CYCLES + IDLE_CYCLES + 50;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    check_init();
    foreach (steps[i]) run_step(steps[i].name, steps[i].write, steps[i].addr,
                                steps[i].data, steps[i].mask);
    // Long idle stretch while refresh keeps running
    ref_start = ref_count;
    repeat (IDLE_CYCLES) @(negedge clock);
    refs = ref_count - ref_start;
    assert (refs >= IDLE_CYCLES / REFRESH_CYCLES - 1) else begin
      errors++;
      $display("Mismatch idle_refresh: expected at least %0d, actual %0d",
               IDLE_CYCLES / REFRESH_CYCLES - 1, refs);
    end
    foreach (steps[i]) begin
      if (steps[i].write) run_step({"idle_", steps[i].name}, 1'b0, steps[i].addr, '0, '0);
    end
    $display("Error counts: %0d testbench, %0d assertion", errors,
             ddr3_lite_top_i.ddr3_lite_checker_i.assert_fails);
    if (errors == 0 && ddr3_lite_top_i.ddr3_lite_checker_i.assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* flist.f */
logic/ddr3_pkg.sv
logic/ddr3_init.sv
logic/ddr3_fsm.sv
logic/ddr3_ddl.sv
logic/ddr3_lite_top.sv
tests/dfi_mem_model.sv
tests/ddr3_lite_checker.sv
tests/ddr3_lite_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the DDR3 controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ddr3_lite_tb \
  -f flist.f -o ddr3_lite_sim
./obj_dir/ddr3_lite_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "^sim passed$" sim.log
